// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= execTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
source/execPkg.sv
source/shifter.sv
source/alu.sv
source/aluDecoder.sv
source/wbExecRegs.sv
source/execTop.sv
verif/execTop_assert.sv
verif/execTb.sv

// ==== source/alu.sv ====
`default_nettype none

module alu import execPkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [XLEN-1:0] b,
  input  logic [2:0]      aluControl,
  input  aluFunctT        funct3,
  output logic [XLEN-1:0] result,
  output logic [XLEN-1:0] sum
);

  logic [XLEN-1:0] condInvB;
  logic [XLEN-1:0] sumTrunc;
  logic [XLEN-1:0] shift;
  logic [XLEN-1:0] slt;
  logic [XLEN-1:0] sltu;
  logic            carry;
  logic            neg;
  logic            overflow;
  logic            lt;
  logic            ltu;
  logic            right;
  logic            w64;
  logic            subArith;
  logic            aluOp;

  // control word is {w64, subArith, aluOp}
  assign {w64, subArith, aluOp} = aluControl;

  ////////////////////
  // adder
  ////////////////////

  // subtract as a + ~b + 1
  assign condInvB     = subArith ? ~b : b;
  assign {carry, sum} = a + condInvB + {{(XLEN-1){1'b0}}, subArith};

  // addw, subw and addiw keep only the low word
  assign sumTrunc = w64 ? {{(XLEN-32){sum[31]}}, sum[31:0]} : sum;

  ////////////////////
  // shifter
  ////////////////////

  // srl and sra share funct3, subArith picks arithmetic
  assign right = (funct3 == fSr);

  shifter shift0 (
    .a     (a),
    .shamt (b[5:0]),
    .right (right),
    .arith (subArith),
    .w64   (w64),
    .y     (shift)
  );

  ////////////////////
  // compare flags
  ////////////////////

  assign neg = sum[XLEN-1];
  // overflow when both addends share a sign and the sum has the other one
  assign overflow = (a[XLEN-1] ~^ condInvB[XLEN-1]) & (a[XLEN-1] ^ sum[XLEN-1]);
  assign lt  = neg ^ overflow;
  // no carry out of a - b means a < b unsigned
  assign ltu = ~carry;

  assign slt  = {{(XLEN-1){1'b0}}, lt};
  assign sltu = {{(XLEN-1){1'b0}}, ltu};

  // result select, aluOp low forces the adder output (lui)
  always_comb begin
    if (!aluOp) begin
      result = sumTrunc;
    end else begin
      case (funct3)
        fAddSub: result = sumTrunc;
        fSll:    result = shift;
        fSlt:    result = slt;
        fSltu:   result = sltu;
        fXor:    result = a ^ b;
        fSr:     result = shift;
        fOr:     result = a | b;
        fAnd:    result = a & b;
        default: result = sumTrunc;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== source/aluDecoder.sv ====
`default_nettype none

module aluDecoder import execPkg::*; (
  input  logic [31:0]     instr,
  output logic [2:0]      aluControl,
  output aluFunctT        funct3,
  output logic            useImm,
  output logic            zeroA,
  output logic [XLEN-1:0] imm,
  output logic            illegal
);

  opcodeT          opcode;
  logic [6:0]      funct7;
  logic [XLEN-1:0] immI;
  logic [XLEN-1:0] immU;
  logic            w64;
  logic            subArith;
  logic            aluOp;
  logic            isCmp;
  logic            altOk;

  ////////////////////
  // fields
  ////////////////////

  assign opcode = opcodeT'(instr[6:0]);
  assign funct3 = aluFunctT'(instr[14:12]);
  assign funct7 = instr[31:25];

  // sign-extended I and U immediates
  assign immI = {{(XLEN-12){instr[31]}}, instr[31:20]};
  assign immU = {{(XLEN-32){instr[31]}}, instr[31:12], 12'b0};

  // slt and sltu need the subtractor
  assign isCmp = (funct3 == fSlt) || (funct3 == fSltu);
  // only add and sr accept the alternate funct7 (sub, sra)
  assign altOk = (funct3 == fAddSub) || (funct3 == fSr);

  assign aluControl = {w64, subArith, aluOp};

  ////////////////////
  // control decode
  ////////////////////

  always_comb begin
    w64      = 1'b0;
    subArith = 1'b0;
    aluOp    = 1'b1;
    useImm   = 1'b0;
    zeroA    = 1'b0;
    imm      = immI;
    illegal  = 1'b0;
    case (opcode)
      opOp: begin
        subArith = (altOk && instr[30]) || isCmp;
        illegal  = !((funct7 == 7'b0000000) || (funct7 == 7'b0100000 && altOk));
      end
      opOpImm: begin
        useImm = 1'b1;
        // addi with bit 30 set is still an add, only srai subtracts
        subArith = ((funct3 == fSr) && instr[30]) || isCmp;
        // 6-bit shamt leaves imm[11:6] as the function field
        if (funct3 == fSll) begin
          illegal = (instr[31:26] != 6'b000000);
        end else if (funct3 == fSr) begin
          illegal = (instr[31:26] != 6'b000000) && (instr[31:26] != 6'b010000);
        end
      end
      opOp32: begin
        w64      = 1'b1;
        subArith = altOk && instr[30];
        // word group has only add, sub, sll, srl and sra
        illegal  = !(altOk || (funct3 == fSll)) ||
                   !((funct7 == 7'b0000000) || (funct7 == 7'b0100000 && altOk));
      end
      opOpImm32: begin
        w64      = 1'b1;
        useImm   = 1'b1;
        subArith = (funct3 == fSr) && instr[30];
        // word shifts take a 5-bit shamt so funct7 is checked whole
        case (funct3)
          fAddSub: illegal = 1'b0;
          fSll:    illegal = (funct7 != 7'b0000000);
          fSr:     illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          default: illegal = 1'b1;
        endcase
      end
      opLui: begin
        // lui is 0 + immU through the adder
        aluOp  = 1'b0;
        useImm = 1'b1;
        zeroA  = 1'b1;
        imm    = immU;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/execPkg.sv ====
`default_nettype none

package execPkg;

  ////////////////////
  // widths
  ////////////////////

  // datapath width, only the 64-bit build exists
  localparam int XLEN = 64;

  // wishbone word address width
  localparam int ADDR_W = 3;

  ////////////////////
  // register map
  ////////////////////

  // word addresses seen on the wishbone port
  typedef enum logic [ADDR_W-1:0] {
    regOpA    = 3'd0,  // rs1 operand, read/write
    regOpB    = 3'd1,  // rs2 operand, read/write
    regInstr  = 3'd2,  // instruction word in the low 32 bits
    regResult = 3'd3,  // alu result, read only
    regStatus = 3'd4   // bit 0 is the illegal flag, read only
  } regAddrT;

  ////////////////////
  // instruction fields
  ////////////////////

  // major opcodes handled by the unit
  typedef enum logic [6:0] {
    opOp      = 7'b0110011,
    opOpImm   = 7'b0010011,
    opOp32    = 7'b0111011,
    opOpImm32 = 7'b0011011,
    opLui     = 7'b0110111
  } opcodeT;

  // funct3 meanings for the integer groups
  typedef enum logic [2:0] {
    fAddSub = 3'b000,
    fSll    = 3'b001,
    fSlt    = 3'b010,
    fSltu   = 3'b011,
    fXor    = 3'b100,
    fSr     = 3'b101,
    fOr     = 3'b110,
    fAnd    = 3'b111
  } aluFunctT;

endpackage

`default_nettype wire

// ==== source/execTop.sv ====
`default_nettype none

module execTop import execPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  regAddrT         adr,
  input  logic [XLEN-1:0] datIn,
  output logic [XLEN-1:0] datOut,
  output logic            ack
);

  logic [XLEN-1:0] opA;
  logic [XLEN-1:0] opB;
  logic [31:0]     instr;
  logic [2:0]      aluControl;
  aluFunctT        funct3;
  logic            useImm;
  logic            zeroA;
  logic [XLEN-1:0] imm;
  logic            illegal;
  logic [XLEN-1:0] aluA;
  logic [XLEN-1:0] aluB;
  logic [XLEN-1:0] result;

  // bus side register block
  wbExecRegs regs0 (
    .clk     (clk),
    .rstN    (rstN),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .datIn   (datIn),
    .result  (result),
    .illegal (illegal),
    .ack     (ack),
    .datOut  (datOut),
    .opA     (opA),
    .opB     (opB),
    .instr   (instr)
  );

  aluDecoder dec0 (
    .instr      (instr),
    .aluControl (aluControl),
    .funct3     (funct3),
    .useImm     (useImm),
    .zeroA      (zeroA),
    .imm        (imm),
    .illegal    (illegal)
  );

  // operand muxes, a is zero for lui and b takes the immediate
  assign aluA = zeroA ? '0 : opA;
  assign aluB = useImm ? imm : opB;

  // raw sum is not needed at this level
  alu alu0 (
    .a          (aluA),
    .b          (aluB),
    .aluControl (aluControl),
    .funct3     (funct3),
    .result     (result),
    .sum        ()
  );

endmodule

`default_nettype wire

// ==== source/shifter.sv ====
`default_nettype none

module shifter import execPkg::*; (
  input  logic [XLEN-1:0] a,
  input  logic [5:0]      shamt,
  input  logic            right,
  input  logic            arith,
  input  logic            w64,
  output logic [XLEN-1:0] y
);

  logic [XLEN-1:0] aIn;
  logic [5:0]      amt;
  logic [XLEN:0]   rightExt;
  logic [XLEN-1:0] rightRes;
  logic [XLEN-1:0] leftRes;
  logic [XLEN-1:0] raw;

  // word mode works on the low half only
  // upper half is refilled so right shifts pull in sign or zero bits
  always_comb begin
    if (w64) begin
      if (arith) begin
        aIn = {{(XLEN-32){a[31]}}, a[31:0]};
      end else begin
        aIn = {{(XLEN-32){1'b0}}, a[31:0]};
      end
      // shamt[5] is ignored for word shifts
      amt = {1'b0, shamt[4:0]};
    end else begin
      aIn = a;
      amt = shamt;
    end
  end

  // one extra fill bit on top turns a signed shift into srl or sra
  assign rightExt = {arith & aIn[XLEN-1], aIn};
  assign rightRes = XLEN'($signed(rightExt) >>> amt);
  assign leftRes  = aIn << amt;

  assign raw = right ? rightRes : leftRes;

  // word results are sign-extended from bit 31
  assign y = w64 ? {{(XLEN-32){raw[31]}}, raw[31:0]} : raw;

endmodule

`default_nettype wire

// ==== source/wbExecRegs.sv ====
`default_nettype none

module wbExecRegs import execPkg::*; (
  input  logic            clk,
  input  logic            rstN,
  input  logic            cyc,
  input  logic            stb,
  input  logic            we,
  input  regAddrT         adr,
  input  logic [XLEN-1:0] datIn,
  input  logic [XLEN-1:0] result,
  input  logic            illegal,
  output logic            ack,
  output logic [XLEN-1:0] datOut,
  output logic [XLEN-1:0] opA,
  output logic [XLEN-1:0] opB,
  output logic [31:0]     instr
);

  logic            access;
  logic [XLEN-1:0] readMux;

  // a new access starts when cyc and stb are high and the last ack is gone
  // this keeps ack to a single cycle while the master still holds stb
  assign access = cyc & stb & ~ack;

  ////////////////////
  // read path
  ////////////////////

  always_comb begin
    case (adr)
      regOpA:    readMux = opA;
      regOpB:    readMux = opB;
      regInstr:  readMux = {{(XLEN-32){1'b0}}, instr};
      regResult: readMux = result;
      regStatus: readMux = {{(XLEN-1){1'b0}}, illegal};
      // unmapped words read as zero
      default:   readMux = '0;
    endcase
  end

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ack    <= 1'b0;
      datOut <= '0;
      opA    <= '0;
      opB    <= '0;
      instr  <= '0;
    end else begin
      ack <= access;
      if (access) begin
        // read data is captured on the edge that raises ack
        datOut <= readMux;
        if (we) begin
          // result, status and unmapped words drop the write
          case (adr)
            regOpA:   opA   <= datIn;
            regOpB:   opB   <= datIn;
            regInstr: instr <= datIn[31:0];
            default: begin
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/execTb.sv ====
`default_nettype none

module execTb import execPkg::*; ();

  logic            clk;
  logic            rstN;
  logic            cyc;
  logic            stb;
  logic            we;
  regAddrT         adr;
  logic [XLEN-1:0] datIn;
  logic [XLEN-1:0] datOut;
  logic            ack;

  // stimulus table, one row per instruction
  logic [31:0]     rowInstr[$];
  logic [XLEN-1:0] rowA[$];
  logic [XLEN-1:0] rowB[$];
  logic [XLEN-1:0] rowRes[$];
  logic            rowIll[$];
  logic            tableReady = 1'b0;
  int              randCount = 200;

  // boundary values and bit patterns
  logic [XLEN-1:0] maxP = 64'h7fff_ffff_ffff_ffff;
  logic [XLEN-1:0] minN = 64'h8000_0000_0000_0000;
  logic [XLEN-1:0] ones = 64'hffff_ffff_ffff_ffff;
  logic [XLEN-1:0] shA  = 64'h8000_0000_0000_0001;
  logic [XLEN-1:0] patX = 64'hff00_ff00_ff00_ff00;
  logic [XLEN-1:0] patY = 64'h0ff0_0ff0_0ff0_0ff0;

  execTop dut0 (
    .clk    (clk),
    .rstN   (rstN),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .datIn  (datIn),
    .datOut (datOut),
    .ack    (ack)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////
  // instruction encoding
  ////////////////////

  // R-type with rd x3, rs1 x1, rs2 x2
  function automatic logic [31:0] encodeR(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [6:0] op);
    return {f7, 5'd2, 5'd1, f3, 5'd3, op};
  endfunction

  // I-type, imm[11:5] doubles as funct7 for shifts
  function automatic logic [31:0] encodeI(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] op);
    return {imm, 5'd1, f3, 5'd3, op};
  endfunction

  function automatic logic [31:0] encodeU(input logic [19:0] imm);
    return {imm, 5'd3, opLui};
  endfunction

  ////////////////////
  // checking and bus access
  ////////////////////

  task automatic check(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                       input string what);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Regression failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // one classic cycle, signals held until ack then stb dropped
  task automatic busAccess(input logic write, input regAddrT addr,
                           input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= addr;
    datIn <= wdata;
    // ack seen here is the value before this edge updates it
    do begin
      @(posedge clk);
    end while (ack !== 1'b1);
    rdata = datOut;
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    // a second ack cycle would show up here
    @(posedge clk);
    check({63'b0, ack}, 64'd0, "ack longer than one cycle");
  endtask

  task automatic writeReg(input regAddrT addr, input logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] unused;
    busAccess(1'b1, addr, wdata, unused);
  endtask

  task automatic readReg(input regAddrT addr, output logic [XLEN-1:0] rdata);
    busAccess(1'b0, addr, '0, rdata);
  endtask

  ////////////////////
  // table
  ////////////////////

  task automatic addRow(input logic [31:0] ins, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic [XLEN-1:0] res,
                        input logic ill);
    rowInstr.push_back(ins);
    rowA.push_back(a);
    rowB.push_back(b);
    rowRes.push_back(res);
    rowIll.push_back(ill);
  endtask

  task automatic buildTable();
    // arithmetic and logic, wrap-around and immediate sign extension
    addRow(encodeR(7'h00, fAddSub, opOp), 64'd5, 64'd7, 64'd12, 1'b0);
    addRow(encodeR(7'h00, fAddSub, opOp), ones, 64'd2, 64'd1, 1'b0);
    addRow(encodeR(7'h20, fAddSub, opOp), 64'd5, 64'd7, 64'hffff_ffff_ffff_fffe, 1'b0);
    addRow(encodeI(12'hfff, fAddSub, opOpImm), 64'd10, 64'd99, 64'd9, 1'b0);
    addRow(encodeI(12'h800, fAddSub, opOpImm), 64'd0, 64'd0, 64'hffff_ffff_ffff_f800, 1'b0);
    addRow(encodeR(7'h00, fXor, opOp), patX, patY, 64'hf0f0_f0f0_f0f0_f0f0, 1'b0);
    addRow(encodeR(7'h00, fOr, opOp), patX, patY, 64'hfff0_fff0_fff0_fff0, 1'b0);
    addRow(encodeR(7'h00, fAnd, opOp), patX, patY, 64'h0f00_0f00_0f00_0f00, 1'b0);
    addRow(encodeI(12'hf0f, fAnd, opOpImm), patY, 64'd0, 64'h0ff0_0ff0_0ff0_0f00, 1'b0);
    addRow(encodeU(20'h12345), ones, ones, 64'h0000_0000_1234_5000, 1'b0);
    addRow(encodeU(20'h80000), 64'd0, 64'd0, 64'hffff_ffff_8000_0000, 1'b0);
    // signed and unsigned compares at the boundaries
    addRow(encodeR(7'h00, fSlt, opOp), minN, maxP, 64'd1, 1'b0);
    addRow(encodeR(7'h00, fSlt, opOp), maxP, minN, 64'd0, 1'b0);
    addRow(encodeR(7'h00, fSlt, opOp), 64'd5, 64'd5, 64'd0, 1'b0);
    addRow(encodeR(7'h00, fSltu, opOp), minN, maxP, 64'd0, 1'b0);
    addRow(encodeR(7'h00, fSltu, opOp), 64'd0, ones, 64'd1, 1'b0);
    addRow(encodeR(7'h00, fSltu, opOp), ones, ones, 64'd0, 1'b0);
    addRow(encodeI(12'h000, fSlt, opOpImm), minN, 64'd0, 64'd1, 1'b0);
    addRow(encodeI(12'hfff, fSltu, opOpImm), 64'd0, 64'd0, 64'd1, 1'b0);
    // shift amounts 0, 1, 31, 32 and 63
    addRow(encodeR(7'h00, fSll, opOp), shA, 64'd0, shA, 1'b0);
    addRow(encodeR(7'h00, fSll, opOp), shA, 64'd63, minN, 1'b0);
    addRow(encodeR(7'h00, fSr, opOp), shA, 64'd31, 64'h0000_0001_0000_0000, 1'b0);
    addRow(encodeR(7'h20, fSr, opOp), shA, 64'd32, 64'hffff_ffff_8000_0000, 1'b0);
    addRow(encodeR(7'h20, fSr, opOp), shA, 64'd63, ones, 1'b0);
    addRow(encodeI(12'h001, fSll, opOpImm), shA, 64'd0, 64'd2, 1'b0);
    addRow(encodeI(12'h020, fSr, opOpImm), shA, 64'd0, 64'h0000_0000_8000_0000, 1'b0);
    addRow(encodeI(12'h41f, fSr, opOpImm), shA, 64'd0, 64'hffff_ffff_0000_0000, 1'b0);
    // word ops sign-extend bit 31
    addRow(encodeR(7'h00, fAddSub, opOp32), 64'h7fff_ffff, 64'd1,
           64'hffff_ffff_8000_0000, 1'b0);
    addRow(encodeR(7'h20, fAddSub, opOp32), 64'h1_0000_0003, 64'd5,
           64'hffff_ffff_ffff_fffe, 1'b0);
    addRow(encodeI(12'h001, fAddSub, opOpImm32), 64'h1_ffff_ffff, 64'd0, 64'd0, 1'b0);
    addRow(encodeR(7'h00, fSll, opOp32), 64'd1, 64'd31, 64'hffff_ffff_8000_0000, 1'b0);
    addRow(encodeR(7'h00, fSr, opOp32), 64'h8000_0000, 64'd31, 64'd1, 1'b0);
    addRow(encodeR(7'h20, fSr, opOp32), 64'h8000_0000, 64'd4, 64'hffff_ffff_f800_0000, 1'b0);
    addRow(encodeI(12'h41f, fSr, opOpImm32), 64'h8000_0000, 64'd0, ones, 1'b0);
    // illegal encodings, load opcode and all ones included
    addRow(encodeR(7'h00, fAddSub, 7'b0000011), 64'd0, 64'd0, 64'd0, 1'b1);
    addRow(32'hffff_ffff, 64'd0, 64'd0, 64'd0, 1'b1);
    addRow(encodeR(7'h20, fXor, opOp), patX, patY, 64'd0, 1'b1);
    addRow(encodeR(7'h00, fSlt, opOp32), 64'd1, 64'd2, 64'd0, 1'b1);
  endtask

  ////////////////////
  // test sequences
  ////////////////////

  task automatic runRow(input logic [31:0] ins, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input logic [XLEN-1:0] res,
                        input logic ill, input string tag);
    logic [XLEN-1:0] rd;
    writeReg(regOpA, a);
    writeReg(regOpB, b);
    writeReg(regInstr, {32'b0, ins});
    readReg(regResult, rd);
    // result of an illegal instruction is undefined
    if (!ill) begin
      check(rd, res, {tag, " result"});
    end
    readReg(regStatus, rd);
    check(rd, {63'b0, ill}, {tag, " illegal flag"});
  endtask

  task automatic checkRegisters();
    logic [XLEN-1:0] rd;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    a = 64'hdead_beef_0123_4567;
    b = 64'h8000_0000_ffff_0001;
    // instruction zero after reset decodes as illegal
    readReg(regInstr, rd);
    check(rd, 64'd0, "instr after reset");
    readReg(regStatus, rd);
    check(rd, 64'd1, "status after reset");
    writeReg(regOpA, a);
    writeReg(regOpB, b);
    // upper half of the instruction write is dropped
    writeReg(regInstr, {32'hffff_ffff, encodeR(7'h00, fAddSub, opOp)});
    readReg(regOpA, rd);
    check(rd, a, "opA readback");
    readReg(regOpB, rd);
    check(rd, b, "opB readback");
    readReg(regInstr, rd);
    check(rd, {32'b0, encodeR(7'h00, fAddSub, opOp)}, "instr readback");
    // read-only and unmapped words
    writeReg(regResult, ones);
    writeReg(regStatus, ones);
    writeReg(regAddrT'(3'd5), ones);
    readReg(regResult, rd);
    check(rd, a + b, "result after write");
    readReg(regStatus, rd);
    check(rd, 64'd0, "status after write");
    readReg(regAddrT'(3'd5), rd);
    check(rd, 64'd0, "unmapped word 5");
    readReg(regAddrT'(3'd7), rd);
    check(rd, 64'd0, "unmapped word 7");
  endtask

  // add, xor and sltu on random operands
  task automatic randomPhase();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp;
    logic [31:0]     ins;
    int              sel;
    for (int i = 0; i < randCount; i++) begin
      a   = {$urandom, $urandom};
      b   = {$urandom, $urandom};
      sel = $urandom_range(2, 0);
      // equal operands now and then for sltu
      if (i % 16 == 0) begin
        b = a;
      end
      case (sel)
        0: begin
          ins = encodeR(7'h00, fAddSub, opOp);
          exp = a + b;
        end
        1: begin
          ins = encodeR(7'h00, fXor, opOp);
          exp = a ^ b;
        end
        default: begin
          ins = encodeR(7'h00, fSltu, opOp);
          exp = (a < b) ? 64'd1 : 64'd0;
        end
      endcase
      runRow(ins, a, b, exp, 1'b0, $sformatf("random %0d", i));
    end
  endtask

  ////////////////////
  // main and watchdog
  ////////////////////

  initial begin
    rstN  = 1'b0;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = regOpA;
    datIn = '0;
    void'($urandom(32'hcabf_ba50));
    buildTable();
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    checkRegisters();
    foreach (rowInstr[i]) begin
      runRow(rowInstr[i], rowA[i], rowB[i], rowRes[i], rowIll[i], $sformatf("row %0d", i));
    end
    randomPhase();
    $display("Regression passed");
    $finish;
  end

  // budget of 12 accesses at 20 units per row, readback counted as 4 rows
  initial begin
    wait (tableReady);
    #((rowInstr.size() + randCount + 4) * 12 * 20 + 1000);
    $display("Simulation timed out waiting for the DUT");
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== verif/execTop_assert.sv ====
`default_nettype none

// wishbone handshake checks on the slave side of execTop
module execTopAssert (
  input logic clk,
  input logic rstN,
  input logic cyc,
  input logic stb,
  input logic ack
);

  ////////////////////
  // handshake
  ////////////////////

  // ack is a single pulse
  ackOnePulse: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
    else $error("ack held high for two cycles");

  // ack answers a strobe seen one edge earlier
  ackAfterStb: assert property (@(posedge clk) disable iff (!rstN)
    ack |-> $past(cyc && stb))
    else $error("ack without a preceding cyc and stb");

  ackNeedsCyc: assert property (@(posedge clk) disable iff (!rstN) !cyc |-> !ack)
    else $error("ack high while cyc is low");

  // synchronous reset clears ack on the next edge
  ackResetLow: assert property (@(posedge clk) !rstN |=> !ack)
    else $error("ack high in the cycle after reset");

endmodule

bind execTop execTopAssert assert0 (
  .clk  (clk),
  .rstN (rstN),
  .cyc  (cyc),
  .stb  (stb),
  .ack  (ack)
);

`default_nettype wire
